//--- build.f
stream_pkg.sv
wb_pipe_if.sv
sram_if.sv
wb_sram_stream.sv
wb_sram_bridge.sv
sram_block.sv
stream_sram_top.sv
stream_sram_properties.sv
tb_stream_sram.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the stream SRAM testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_stream_sram \
   -f build.f \
   -o sim_stream_sram

./obj_dir/sim_stream_sram | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
echo "Run passed"

//--- sram_block.sv
`timescale 1ns/1ps

// Behavioral synchronous SRAM, byte-lane writes, TICKS-cycle reads
module sram_block #(
   parameter int unsigned WIDTH = 16,                 // Word width
   parameter int unsigned WBITS = 4,                  // Address width
   parameter int unsigned BYTES = 2,                  // Byte lanes
   parameter int unsigned TICKS = 1                   // Read latency, at least 1
) (
   input  logic     clk_i,
   sram_if.memory   mem_m
);

   localparam int unsigned LANE = WIDTH / BYTES;      // Bits per byte lane

   logic [WIDTH-1:0] mem [2**WBITS];                  // Storage array
   logic [WIDTH-1:0] rd_q [TICKS];                    // Read delay line

   // ----------------------------------------
   // Write port
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (mem_m.ce && mem_m.we) begin
         for (int b = 0; b < BYTES; b++) begin
            if (mem_m.be[b]) begin
               mem[mem_m.ad][b*LANE +: LANE] <= mem_m.di[b*LANE +: LANE];
            end
         end
      end
   end

   // ----------------------------------------
   // Read port
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (mem_m.ce && !mem_m.we) begin
         rd_q[0] <= mem[mem_m.ad];                    // First stage samples the array
      end
      for (int i = 1; i < TICKS; i++) begin
         rd_q[i] <= rd_q[i-1];                        // Remaining stages just delay
      end
   end

   assign mem_m.dout = rd_q[TICKS-1];

endmodule : sram_block

//--- sram_if.sv
`timescale 1ns/1ps

// Synchronous SRAM command and data port
interface sram_if
   import stream_pkg::*;
#(
   parameter int unsigned WIDTH = DEF_WIDTH,          // Data width
   parameter int unsigned WBITS = DEF_WBITS,          // Address width
   parameter int unsigned BYTES = DEF_BYTES           // Byte enables
);

   logic             ce;                              // Chip enable, one command per cycle
   logic             we;                              // Write when high, read when low
   logic [BYTES-1:0] be;                              // Byte enables for writes
   logic [WBITS-1:0] ad;                              // Word address
   logic [WIDTH-1:0] di;                              // Write data into the array
   logic [WIDTH-1:0] dout;                            // Read data, TICKS cycles after ce

   modport controller (
      output ce, we, be, ad, di,
      input  dout
   );

   modport memory (
      input  ce, we, be, ad, di,
      output dout
   );

endinterface : sram_if

//--- stream_pkg.sv
package stream_pkg;

   // ----------------------------------------
   // Default sizes of the streaming subsystem
   // ----------------------------------------
   localparam int unsigned DEF_WIDTH = 16;            // Data word width
   localparam int unsigned DEF_WBITS = 4;             // Word address width
   localparam int unsigned DEF_BYTES = 2;             // Byte enables per word

   // ----------------------------------------
   // Kind of an accepted bus request
   // ----------------------------------------
   // Travels down the bridge pipeline next to a valid bit,
   // so no idle code is needed here
   typedef enum logic [1:0] {
      KIND_READ  = 2'b00,                             // Read, returns dat_r with ack
      KIND_WRITE = 2'b01,                             // Write, ack only
      KIND_ERR   = 2'b10                              // No byte selected, err only
   } req_kind_e;

endpackage : stream_pkg

//--- stream_sram_properties.sv
`timescale 1ns/1ps

// Port-level checks on the streaming subsystem
module stream_sram_properties (
   input logic clk_i,
   input logic reset_i,
   input logic ack_o,
   input logic stall_o,
   input logic err_o,
   input logic wrapped_o
);

   // ----------------------------------------
   // Response and pulse shape
   // ----------------------------------------
   assert property (@(posedge clk_i) disable iff (reset_i) !(ack_o && err_o))
      else $error("ack_o and err_o high in the same cycle");

   assert property (@(posedge clk_i) disable iff (reset_i) wrapped_o |=> !wrapped_o)
      else $error("wrapped_o high for two cycles");

   assert property (@(posedge clk_i) disable iff (reset_i) stall_o |=> !stall_o)
      else $error("stall_o high for two cycles");

   assert property (@(posedge clk_i) reset_i |=> !ack_o && !err_o && !stall_o && !wrapped_o)
      else $error("outputs not low after reset");

endmodule : stream_sram_properties

bind stream_sram_top stream_sram_properties u_props (
   .clk_i    (clk_i),
   .reset_i  (reset_i),
   .ack_o    (ack_o),
   .stall_o  (stall_o),
   .err_o    (err_o),
   .wrapped_o(wrapped_o)
);

//--- stream_sram_top.sv
`timescale 1ns/1ps

module stream_sram_top
   import stream_pkg::*;
#(
   parameter int unsigned WIDTH = DEF_WIDTH,          // Data width
   parameter int unsigned WBITS = DEF_WBITS,          // SRAM address width
   parameter int unsigned BYTES = DEF_BYTES,          // Byte enables
   parameter int unsigned START = 2,                  // Stream window start
   parameter int unsigned LAST  = 13,                 // Stream window end
   parameter int unsigned STEP  = 1,                  // Address step
   parameter int unsigned TICKS = 1                   // SRAM read latency
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [BYTES-1:0] sel_i,
   input  logic [WIDTH-1:0] dat_i,
   output logic             ack_o,
   output logic             stall_o,
   output logic             err_o,
   output logic [WIDTH-1:0] dat_o,
   output logic             wrapped_o
);

   // ----------------------------------------
   // Internal links
   // ----------------------------------------
   wb_pipe_if #(.WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES)) wb_bus ();
   sram_if    #(.WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES)) mem_bus ();

   // Address generator and wrap detect
   wb_sram_stream #(
      .WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES),
      .START(START), .LAST(LAST), .STEP(STEP)
   ) u_stream (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .cyc_i    (cyc_i),
      .stb_i    (stb_i),
      .we_i     (we_i),
      .sel_i    (sel_i),
      .dat_i    (dat_i),
      .dat_o    (dat_o),
      .ack_o    (ack_o),
      .stall_o  (stall_o),
      .err_o    (err_o),
      .wrapped_o(wrapped_o),
      .bus_m    (wb_bus.master)
   );

   // Wishbone to SRAM command conversion
   wb_sram_bridge #(
      .WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES), .TICKS(TICKS)
   ) u_bridge (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .bus_s  (wb_bus.slave),
      .mem_c  (mem_bus.controller)
   );

   sram_block #(
      .WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES), .TICKS(TICKS)
   ) u_sram (
      .clk_i(clk_i),
      .mem_m(mem_bus.memory)
   );

endmodule : stream_sram_top

//--- tb_stream_sram.sv
`timescale 1ns/1ps

module tb_stream_sram;

   localparam int WIDTH   = 16;
   localparam int WBITS   = 4;
   localparam int BYTES   = 2;
   localparam int LANE    = WIDTH / BYTES;           // Bits per byte lane
   localparam int START   = 2;                       // Stream window
   localparam int LAST    = 13;
   localparam int STEP    = 1;
   localparam int TICKS   = 1;                       // SRAM read latency
   localparam int TIMEOUT = 50;                      // Cycles allowed per wait
   localparam logic [15:0] SEED = 16'd31;

   // Expected response of one accepted request
   typedef struct packed {
      logic             err;                         // Err instead of ack
      logic             rd;                          // Read data to compare
      logic [WIDTH-1:0] dat;
      logic [31:0]      cyc;                         // Sample index at acceptance
   } resp_t;

   logic             clk_i;
   logic             reset_i;
   logic             cyc_i;
   logic             stb_i;
   logic             we_i;
   logic [BYTES-1:0] sel_i;
   logic [WIDTH-1:0] dat_i;
   logic [WIDTH-1:0] dat_o;
   logic             ack_o;
   logic             stall_o;
   logic             err_o;
   logic             wrapped_o;

   logic [WIDTH-1:0] ref_mem [2**WBITS];             // Reference memory
   resp_t            exp_q [$];                      // Responses in flight
   logic [WBITS-1:0] tb_adr;                         // Own address counter
   logic [1:0]       wrap_pipe;                      // Expected wrap pulse timing
   logic [15:0]      lfsr;
   int               errors;
   int               sample_num;
   int               acks;
   int               errs;
   int               wraps;
   int               stalls;

   stream_sram_top #(
      .WIDTH(WIDTH), .WBITS(WBITS), .BYTES(BYTES),
      .START(START), .LAST(LAST), .STEP(STEP), .TICKS(TICKS)
   ) DUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic random_word(output logic [WIDTH-1:0] w);
      w = '0;
      for (int i = 0; i < WIDTH; i++) begin
         lfsr = lfsr_next(lfsr);                     // One step per bit
         w    = {w[WIDTH-2:0], lfsr[0]};
      end
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      errors++;
      $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, got);
   endtask

   task automatic end_run();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("timeout at %0t: %s", $time, what);
   endtask

   task automatic check_response();
      resp_t r;
      if (exp_q.size() == 0) begin
         errors++;
         $display("response at %0t with no request in flight", $time);
      end else begin
         r = exp_q.pop_front();
         if (err_o !== r.err) report_mismatch("err_o", 32'(r.err), 32'(err_o));
         if (ack_o !== ~r.err) report_mismatch("ack_o", 32'(~r.err), 32'(ack_o));
         if (r.rd && dat_o !== r.dat) report_mismatch("dat_o", 32'(r.dat), 32'(dat_o));
         if (sample_num != r.cyc + TICKS + 2) begin  // TICKS+1 cycles after acceptance
            report_mismatch("response latency", TICKS + 2, sample_num - r.cyc);
         end
      end
   endtask

   // Predict the response and update the model at acceptance
   task automatic record_request();
      resp_t r;
      r.err = (sel_i == '0);
      r.rd  = !we_i && !r.err;
      r.dat = ref_mem[tb_adr];
      r.cyc = sample_num;
      if (!r.err) begin
         for (int b = 0; b < BYTES; b++) begin
            if (we_i && sel_i[b]) ref_mem[tb_adr][b*LANE +: LANE] = dat_i[b*LANE +: LANE];
         end
         wrap_pipe[0] = (tb_adr == WBITS'(LAST));
         tb_adr = (tb_adr == WBITS'(LAST)) ? WBITS'(START) : tb_adr + WBITS'(STEP);
      end
      exp_q.push_back(r);
   endtask

   // Sample at the falling edge, return just after the next rising edge
   task automatic cycle_step(output logic accepted);
      @(negedge clk_i);
      sample_num++;
      accepted = cyc_i && stb_i && !stall_o;         // Taken at the coming edge
      if (wrapped_o !== wrap_pipe[1]) begin
         report_mismatch("wrapped_o", 32'(wrap_pipe[1]), 32'(wrapped_o));
      end
      if (ack_o || err_o) check_response();
      if (ack_o) acks++;
      if (err_o) errs++;
      if (wrapped_o) wraps++;
      if (stall_o) stalls++;
      wrap_pipe = {wrap_pipe[0], 1'b0};
      if (accepted) record_request();
      @(posedge clk_i);
   endtask

   task automatic send(input logic we, input logic [BYTES-1:0] sel, input logic [WIDTH-1:0] dat);
      logic accepted;
      int   waited;
      accepted = 1'b0;
      waited   = 0;
      cyc_i <= 1'b1;
      stb_i <= 1'b1;
      we_i  <= we;
      sel_i <= sel;
      dat_i <= dat;
      while (!accepted && waited < TIMEOUT) begin   // Held while stalled
         cycle_step(accepted);
         waited++;
      end
      if (!accepted) report_timeout("request never accepted");
   endtask

   task automatic drain();
      logic accepted;
      int   waited;
      waited = 0;
      stb_i <= 1'b0;
      while (exp_q.size() != 0 && waited < TIMEOUT) begin
         cycle_step(accepted);
         waited++;
      end
      repeat (2) cycle_step(accepted);               // Catch stray responses
      if (exp_q.size() != 0) report_timeout("responses missing after the stream");
   endtask

   task automatic apply_reset();
      reset_i <= 1'b1;
      cyc_i   <= 1'b0;
      stb_i   <= 1'b0;
      we_i    <= 1'b0;
      sel_i   <= '0;
      dat_i   <= '0;
      repeat (3) @(posedge clk_i);
      reset_i <= 1'b0;
      cyc_i   <= 1'b1;
      exp_q.delete();                                // In-flight work is dropped
      wrap_pipe = '0;
      tb_adr    = WBITS'(START);
   endtask

   task automatic clear_counts();
      acks   = 0;
      errs   = 0;
      wraps  = 0;
      stalls = 0;
   endtask

   task automatic expect_counts(input int n_ack, input int n_err, input int n_wrap,
                                input int n_stall);
      if (acks != n_ack) report_mismatch("ack_o count", n_ack, acks);
      if (errs != n_err) report_mismatch("err_o count", n_err, errs);
      if (wraps != n_wrap) report_mismatch("wrapped_o count", n_wrap, wraps);
      if (stalls != n_stall) report_mismatch("stall_o count", n_stall, stalls);
   endtask

   // ----------------------------------------
   // Directed tests
   // ----------------------------------------
   task automatic write_stream_wrap();
      logic [WIDTH-1:0] w;
      clear_counts();
      repeat (12) begin
         random_word(w);
         send(1'b1, '1, w);
      end
      drain();
      expect_counts(12, 0, 1, 0);
   endtask

   task automatic read_back_order();
      clear_counts();
      repeat (14) send(1'b0, '1, '0);                // Wraps back to START
      drain();
      expect_counts(14, 0, 1, 0);
   endtask

   task automatic merge_low_byte();
      logic [WIDTH-1:0] w;
      clear_counts();
      random_word(w);
      send(1'b1, BYTES'(1), w);
      repeat (12) send(1'b0, '1, '0);                // Last read hits the merged word
      drain();
      expect_counts(13, 0, 1, 1);
   endtask

   task automatic reject_empty_select();
      clear_counts();
      send(1'b0, '0, '0);
      send(1'b0, '1, '0);                            // Same address as the rejected one
      drain();
      expect_counts(1, 1, 0, 0);
   endtask

   task automatic stall_read_after_write();
      logic [WIDTH-1:0] w;
      clear_counts();
      random_word(w);
      send(1'b1, '1, w);
      send(1'b0, '1, '0);
      drain();
      expect_counts(2, 0, 0, 1);
   endtask

   task automatic reset_mid_stream();
      logic [WIDTH-1:0] w;
      repeat (4) begin
         random_word(w);
         send(1'b1, '1, w);
      end
      apply_reset();
      clear_counts();
      send(1'b0, '1, '0);                            // Expect the word at START
      drain();
      expect_counts(1, 0, 0, 0);
   endtask

   initial begin
      errors     = 0;
      sample_num = 0;
      lfsr       = SEED;
      clear_counts();
      apply_reset();
      write_stream_wrap();
      read_back_order();
      merge_low_byte();
      reject_empty_select();
      stall_read_after_write();
      reset_mid_stream();
      end_run();
   end

endmodule : tb_stream_sram

//--- wb_pipe_if.sv
`timescale 1ns/1ps

// Pipelined Wishbone link between the stream port and the bridge
interface wb_pipe_if
   import stream_pkg::*;
#(
   parameter int unsigned WIDTH = DEF_WIDTH,          // Data width
   parameter int unsigned WBITS = DEF_WBITS,          // Address width
   parameter int unsigned BYTES = DEF_BYTES           // Select lines
);

   // ----------------------------------------
   // Request side
   // ----------------------------------------
   logic             cyc;                             // Bus cycle in progress
   logic             stb;                             // Request strobe
   logic             we;                              // Write request
   logic [BYTES-1:0] sel;                             // Byte selects
   logic [WBITS-1:0] adr;                             // Word address from the counter
   logic [WIDTH-1:0] dat_w;                           // Write data

   // ----------------------------------------
   // Response side
   // ----------------------------------------
   logic [WIDTH-1:0] dat_r;                           // Read data, valid with ack
   logic             ack;                             // Normal completion
   logic             stall;                           // Request not taken this cycle
   logic             err;                             // Error completion

   // Stream port side
   modport master (
      output cyc, stb, we, sel, adr, dat_w,
      input  dat_r, ack, stall, err
   );

   // Bridge side
   modport slave (
      input  cyc, stb, we, sel, adr, dat_w,
      output dat_r, ack, stall, err
   );

endinterface : wb_pipe_if

//--- wb_sram_bridge.sv
`timescale 1ns/1ps

// Pipelined Wishbone slave in front of a synchronous SRAM
module wb_sram_bridge
   import stream_pkg::*;
#(
   parameter int unsigned WIDTH = 16,                 // Data width
   parameter int unsigned WBITS = 4,                  // Address width
   parameter int unsigned BYTES = 2,                  // Byte enables
   parameter int unsigned TICKS = 1                   // SRAM read latency, at least 1
) (
   input  logic        clk_i,
   input  logic        reset_i,
   wb_pipe_if.slave    bus_s,
   sram_if.controller  mem_c
);

   // ----------------------------------------
   // Request decode
   // ----------------------------------------
   logic             accept_w;                        // Handshake completes at this edge
   logic             stall_w;                         // Turnaround stall
   req_kind_e        kind_w;                          // Kind of the presented request
   logic             wr_last_q;                       // A write was accepted last edge

   // SRAM command registers
   logic             ce_q;
   logic             we_q;
   logic [BYTES-1:0] be_q;
   logic [WBITS-1:0] ad_q;
   logic [WIDTH-1:0] di_q;

   // Response timing pipeline
   logic [TICKS:0]   vld_q;                           // Occupied stages
   req_kind_e        kind_q [TICKS+1];                // Kind per stage
   logic             ack_q;
   logic             err_q;
   logic [WIDTH-1:0] dat_r_q;                         // Captured read word

   assign kind_w = (bus_s.sel == '0) ? KIND_ERR :
                   (bus_s.we ? KIND_WRITE : KIND_READ);

   // Read right behind a write waits one cycle for the bus turnaround
   assign stall_w  = wr_last_q && bus_s.cyc && bus_s.stb && !bus_s.we;
   assign accept_w = bus_s.cyc && bus_s.stb && !stall_w;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_last_q <= 1'b0;
      end else begin
         wr_last_q <= accept_w && (kind_w == KIND_WRITE);
      end
   end

   // ----------------------------------------
   // SRAM command, registered at acceptance
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ce_q <= 1'b0;
      end else begin
         ce_q <= accept_w && (kind_w != KIND_ERR);    // Rejected requests never reach the SRAM
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept_w) begin
         we_q <= bus_s.we;
         be_q <= bus_s.sel;                           // Only selected lanes get written
         ad_q <= bus_s.adr;
         di_q <= bus_s.dat_w;
      end
   end

   // ----------------------------------------
   // Kind pipeline, depth TICKS+1
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i || !bus_s.cyc) begin
         vld_q <= '0;                                 // Dropped cycle discards in-flight work
      end else begin
         vld_q[0] <= accept_w;
         for (int i = 1; i <= TICKS; i++) begin
            vld_q[i] <= vld_q[i-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      kind_q[0] <= kind_w;
      for (int i = 1; i <= TICKS; i++) begin
         kind_q[i] <= kind_q[i-1];
      end
   end

   // Responses come out in acceptance order, TICKS+1 edges after the request
   always_ff @(posedge clk_i) begin
      if (reset_i || !bus_s.cyc) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= vld_q[TICKS] && (kind_q[TICKS] != KIND_ERR);
         err_q <= vld_q[TICKS] && (kind_q[TICKS] == KIND_ERR);
      end
   end

   always_ff @(posedge clk_i) begin
      if (vld_q[TICKS] && (kind_q[TICKS] == KIND_READ)) begin
         dat_r_q <= mem_c.dout;                       // SRAM word is valid in this cycle
      end
   end

   // ----------------------------------------
   // Outputs
   // ----------------------------------------
   assign bus_s.stall = stall_w;
   assign bus_s.ack   = ack_q;
   assign bus_s.err   = err_q;
   assign bus_s.dat_r = dat_r_q;

   assign mem_c.ce = ce_q;
   assign mem_c.we = we_q;
   assign mem_c.be = be_q;
   assign mem_c.ad = ad_q;
   assign mem_c.di = di_q;

endmodule : wb_sram_bridge

//--- wb_sram_stream.sv
`timescale 1ns/1ps

// Stream port: the master sends no address, the counter here supplies it
module wb_sram_stream #(
   parameter int unsigned WIDTH = 16,                 // Data width
   parameter int unsigned WBITS = 4,                  // Address width
   parameter int unsigned BYTES = 2,                  // Select lines
   parameter int unsigned START = 0,                  // First address of the window
   parameter int unsigned LAST  = 15,                 // Last address before the wrap
   parameter int unsigned STEP  = 1                   // Address increment
) (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [BYTES-1:0] sel_i,
   input  logic [WIDTH-1:0] dat_i,
   output logic [WIDTH-1:0] dat_o,
   output logic             ack_o,
   output logic             stall_o,
   output logic             err_o,
   output logic             wrapped_o,
   wb_pipe_if.master        bus_m
);

   logic [WBITS-1:0] adr_q;                           // Address counter
   logic             wrap_q;                          // Last counted request was at LAST
   logic             wrap_d_q;                        // Delayed copy of wrap_q
   logic             wrapped_q;                       // Registered wrap pulse
   logic             accept_w;                        // Request taken at this edge
   logic             count_w;                         // Request moves the counter
   logic             at_last_w;                       // Counter sits on LAST

   // ----------------------------------------
   // Request forwarding
   // ----------------------------------------
   assign bus_m.cyc   = cyc_i;
   assign bus_m.stb   = stb_i;
   assign bus_m.we    = we_i;
   assign bus_m.sel   = sel_i;
   assign bus_m.dat_w = dat_i;
   assign bus_m.adr   = adr_q;                        // Counter replaces the master address

   assign dat_o   = bus_m.dat_r;                      // Responses go straight back
   assign ack_o   = bus_m.ack;
   assign err_o   = bus_m.err;
   assign stall_o = bus_m.stall;

   assign accept_w  = cyc_i && stb_i && !bus_m.stall; // Wishbone pipelined handshake
   assign count_w   = accept_w && (sel_i != '0);      // Empty select is rejected, no advance
   assign at_last_w = (adr_q == WBITS'(LAST));

   // ----------------------------------------
   // Address counter
   // ----------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         adr_q <= WBITS'(START);
      end else if (count_w) begin
         adr_q <= at_last_w ? WBITS'(START) : adr_q + WBITS'(STEP);
      end
   end

   // Wrap flag follows every counted request, the pulse marks its rising edge
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wrap_q    <= 1'b0;
         wrap_d_q  <= 1'b0;
         wrapped_q <= 1'b0;
      end else begin
         if (count_w) begin
            wrap_q <= at_last_w;                      // Set at the LAST acceptance edge
         end
         wrap_d_q  <= wrap_q;
         wrapped_q <= wrap_q && !wrap_d_q;            // One cycle, one edge after acceptance
      end
   end

   assign wrapped_o = wrapped_q;

endmodule : wb_sram_stream
